// ==== sources.f ====
logic/cpuPkg.sv
logic/ctrlIf.sv
logic/alu.sv
logic/regFile.sv
logic/dataMem.sv
logic/controlDecoder.sv
logic/fetchUnit.sv
logic/cpuTop.sv
bench/cpuBench.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing -j 0
TOP      ?= cpuBench
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/cpuBench.sv ====
// testbench for cpuTop; loads random and directed programs and checks each cycle against a reference model
`default_nettype none

module cpuBench;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [8:0] haltInstr  = 9'h1F0;
  localparam int         cycleLimit = 4 * (64 + 70) + 164;   // 700 cycles

  typedef struct packed {
    logic       regWe;
    logic [3:0] regAddr;
    logic [7:0] regData;
    logic       memWe;
    logic [7:0] memAddr;
    logic [7:0] memData;
    logic [7:0] nextPc;
    logic       halt;
  } traceT;

  logic       clk = 1'b0;
  logic       arstN;
  logic       progWe;
  logic [7:0] progAddr;
  logic [8:0] progData;
  logic       start;
  logic       done;
  logic [7:0] pc;
  logic       regWriteEn;
  logic [3:0] regWriteAddr;
  logic [7:0] regWriteData;
  logic       memWriteEn;
  logic [7:0] memAddr;
  logic [7:0] memWriteData;

  logic [8:0]  prog [256];   // mirror of the program store
  logic [7:0]  refRegs [16];
  logic [7:0]  refMem [256];
  logic [7:0]  refPc;
  logic        refRunning;
  logic        expectDone;
  logic [31:0] seed = 32'h4f04;
  traceT       want;
  int          errors = 0;
  int          retired = 0;
  int          cycles = 0;

  cpuTop #(.progDepth(256)) DUT (
    .clk, .arstN, .progWe, .progAddr, .progData, .start, .done, .pc,
    .regWriteEn, .regWriteAddr, .regWriteData, .memWriteEn, .memAddr, .memWriteData
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // one instruction on the bench's own state
  function automatic traceT refStep(input logic [8:0] ins, input logic [7:0] curPc);
    traceT       t;
    logic [7:0]  a;
    logic [7:0]  b;
    logic [15:0] wide;
    logic        cond;
    t = '0;
    a = refRegs[0];
    b = refRegs[1];
    t.nextPc  = curPc + 8'd1;
    t.regWe   = 1'b1;
    t.regAddr = ins[3:0];
    case (ins[8:6])
      3'b000: begin
        case (ins[5:4])
          2'b00: t.regData = a + b;
          2'b01: t.regData = a - b;
          2'b10: t.regData = refMem[a];
          default: begin   // store through r0
            t.regWe   = 1'b0;
            t.memWe   = 1'b1;
            t.memAddr = a;
            t.memData = refRegs[ins[3:0]];
          end
        endcase
      end
      3'b001: begin
        t.regAddr = {3'b000, ins[0]};
        t.regData = refMem[cpuPkg::addrTable[ins[5:1]]];
      end
      3'b010: begin
        t.regWe   = 1'b0;
        t.memWe   = 1'b1;
        t.memAddr = cpuPkg::addrTable[ins[5:1]];
        t.memData = refRegs[{3'b000, ins[0]}];
      end
      3'b011: begin
        t.regAddr = 4'd1;
        t.regData = a + {3'b000, ins[5:1]};
      end
      3'b100: begin
        t.regWe = 1'b0;
        case (ins[5:4])
          2'b00: cond = (a == b);
          2'b01: cond = (a != b);
          2'b10: cond = (a < b);
          default: cond = (a <= b);
        endcase
        if (cond) begin
          t.nextPc = cpuPkg::jumpTable[ins[3:0]];
        end
      end
      3'b101: begin
        if (ins[5]) begin
          t.regAddr = ins[4:1];
          t.regData = refRegs[{3'b000, ins[0]}];
        end else begin
          t.regAddr = {3'b000, ins[4]};
          t.regData = refRegs[ins[3:0]];
        end
      end
      3'b110: begin
        wide = {{8{a[7]}}, a} >> b[2:0];   // sign-filled shift
        case (ins[5:4])
          2'b00: t.regData = a << b[2:0];
          2'b01: t.regData = wide[7:0];
          2'b10: t.regData = a >> b[2:0];
          default: t.regData = ~a;
        endcase
      end
      default: begin
        wide = a * b;
        case (ins[5:4])
          2'b00: t.regData = a & b;
          2'b01: t.regData = a | b;
          2'b10: t.regData = wide[7:0];
          default: begin
            t.regWe  = 1'b0;
            t.halt   = 1'b1;
            t.nextPc = curPc;   // pc holds once halted
          end
        endcase
      end
    endcase
    return t;
  endfunction

  task automatic expectEq(input string name, input logic [31:0] expVal,
                          input logic [31:0] gotVal);
    if (expVal !== gotVal) begin
      errors++;
      $display("[ERROR] %s expected 0x%h got 0x%h at pc 0x%h", name, expVal, gotVal, refPc);
    end
  endtask

  // compare at mid-cycle where the trace ports are settled
  always @(negedge clk) begin
    if (!arstN) begin
      for (int i = 0; i < 256; i++) begin
        refMem[8'(i)] = 8'd0;
      end
      for (int i = 0; i < 16; i++) begin
        refRegs[4'(i)] = 8'd0;
      end
      refPc      = 8'd0;
      refRunning = 1'b0;
      expectDone = 1'b0;
    end else if (refRunning) begin
      want = refStep(prog[refPc], refPc);
      expectEq("pc", 32'(refPc), 32'(pc));
      expectEq("done", 32'd0, 32'(done));
      expectEq("regWriteEn", 32'(want.regWe), 32'(regWriteEn));
      expectEq("memWriteEn", 32'(want.memWe), 32'(memWriteEn));
      if (want.regWe) begin
        expectEq("regWriteAddr", 32'(want.regAddr), 32'(regWriteAddr));
        expectEq("regWriteData", 32'(want.regData), 32'(regWriteData));
        refRegs[want.regAddr] = want.regData;
      end
      if (want.memWe) begin
        expectEq("memAddr", 32'(want.memAddr), 32'(memAddr));
        expectEq("memWriteData", 32'(want.memData), 32'(memWriteData));
        refMem[want.memAddr] = want.memData;
      end
      refPc = want.nextPc;
      retired++;
      if (want.halt) begin
        refRunning = 1'b0;
        expectDone = 1'b1;
      end
    end else begin   // idle or halted so nothing may retire
      expectEq("pc", 32'(refPc), 32'(pc));
      expectEq("done", 32'(expectDone), 32'(done));
      expectEq("regWriteEn", 32'd0, 32'(regWriteEn));
      expectEq("memWriteEn", 32'd0, 32'(memWriteEn));
      if (start) begin   // runs from the next edge
        refRunning = 1'b1;
        refPc      = 8'd0;
        expectDone = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == cycleLimit) begin
      $display("timeout: done never rose within %0d cycles", cycleLimit);
      $display("retired %0d instructions, %0d errors", retired, errors);
      $display("tests failed");
      $finish;
    end
  end

  task automatic makeRandomProgram();
    logic [8:0] ins;
    for (int i = 0; i < 60; i++) begin
      do begin
        seed = lcgNext(seed);
        ins  = seed[24:16];
      end while (ins[8:6] == 3'b100 || ins[8:4] == 5'b11111);   // neither branch nor halt
      prog[8'(i)] = ins;
    end
    prog[8'd60] = haltInstr;
  endtask

  // every branch condition once taken and once not taken
  task automatic makeBranchProgram();
    for (int i = 0; i < 36; i++) begin
      prog[8'(i)] = haltInstr;
    end
    prog[8'h00] = {3'b011, 5'd0, 1'b0};        // r1 = r0
    prog[8'h01] = {3'b000, 2'b01, 4'd0};       // r0 = 0
    prog[8'h02] = {3'b011, 5'd0, 1'b0};        // r1 = 0
    prog[8'h03] = {3'b100, 2'b01, 4'd1};       // bne not taken
    prog[8'h04] = {3'b100, 2'b00, 4'd1};       // beq to 0x08
    prog[8'h08] = {3'b100, 2'b11, 4'd2};       // ble to 0x10
    prog[8'h10] = {3'b100, 2'b10, 4'd3};       // blt not taken
    prog[8'h11] = {3'b011, 5'd3, 1'b0};        // r1 = 3
    prog[8'h12] = {3'b100, 2'b00, 4'd3};       // beq not taken
    prog[8'h13] = {3'b100, 2'b10, 4'd3};       // blt to 0x18
    prog[8'h18] = {3'b100, 2'b01, 4'd4};       // bne to 0x20
    prog[8'h20] = {3'b101, 1'b1, 4'd0, 1'b1};  // r0 = r1
    prog[8'h21] = {3'b000, 2'b01, 4'd1};       // r1 = 0
    prog[8'h22] = {3'b100, 2'b11, 4'd5};       // ble not taken
    prog[8'h23] = haltInstr;
  endtask

  task automatic loadProgram(input int len);
    for (int i = 0; i < len; i++) begin
      @(posedge clk);
      progWe   <= 1'b1;
      progAddr <= 8'(i);
      progData <= prog[8'(i)];
    end
    @(posedge clk);
    progWe <= 1'b0;
  endtask

  task automatic runProgram();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    do begin
      @(negedge clk);
    end while (!done);
    repeat (3) @(negedge clk);   // done must hold with no stray writes
  endtask

  initial begin
    arstN    = 1'b0;
    progWe   = 1'b0;
    progAddr = 8'd0;
    progData = 9'd0;
    start    = 1'b0;
    repeat (4) @(posedge clk);
    arstN <= 1'b1;
    for (int p = 0; p < 4; p++) begin
      if (p == 2) begin
        makeBranchProgram();
        loadProgram(36);
      end else begin
        makeRandomProgram();
        loadProgram(61);
      end
      runProgram();
    end
    $display("retired %0d instructions, %0d errors", retired, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/cpuTop.sv ====
// processor top level; load a program through progWe, pulse start, watch the write trace
`default_nettype none

module cpuTop #(
  parameter int progDepth = 256
) (
  input  logic       clk,
  input  logic       arstN,
  input  logic       progWe,
  input  logic [7:0] progAddr,
  input  logic [8:0] progData,
  input  logic       start,
  output logic       done,
  output logic [7:0] pc,
  output logic       regWriteEn,
  output logic [3:0] regWriteAddr,
  output logic [7:0] regWriteData,
  output logic       memWriteEn,
  output logic [7:0] memAddr,
  output logic [7:0] memWriteData
);

  ctrlIf ctrl ();

  logic [8:0] instr;
  logic       active;
  logic [7:0] datA;
  logic [7:0] datB;
  logic [7:0] aluResult;
  logic [7:0] memOut;
  logic [7:0] writeData;
  logic [7:0] memIn;

  fetchUnit #(.progDepth(progDepth)) uFetch (
    .clk, .arstN, .progWe, .progAddr, .progData, .start,
    .ctrl(ctrl.fetch), .instr, .pc, .active, .done
  );

  controlDecoder uDecoder (
    .instr, .active, .datA, .datB, .aluResult, .memOut,
    .ctrl(ctrl.decoder), .writeData, .memIn
  );

  regFile uRegs (.clk, .arstN, .ctrl(ctrl.rf), .writeData, .datA, .datB);

  alu uAlu (.ctrl(ctrl.ex), .datA, .datB, .aluResult);

  dataMem uMem (.clk, .arstN, .ctrl(ctrl.mem), .memIn, .memOut);

  // retired-write trace valid during the instruction's cycle
  assign regWriteEn   = ctrl.regWrite;
  assign regWriteAddr = ctrl.wrAddr;
  assign regWriteData = writeData;
  assign memWriteEn   = ctrl.memWrite;
  assign memAddr      = ctrl.memAddr;
  assign memWriteData = memIn;

endmodule

`default_nettype wire

// ==== logic/fetchUnit.sv ====
// program store, pc and run state; loads the program and sequences fetch one instruction per cycle
`default_nettype none

module fetchUnit #(
  parameter int progDepth = 256
) (
  input  logic       clk,
  input  logic       arstN,
  input  logic       progWe,
  input  logic [7:0] progAddr,
  input  logic [8:0] progData,
  input  logic       start,
  ctrlIf.fetch       ctrl,
  output logic [8:0] instr,
  output logic [7:0] pc,
  output logic       active,
  output logic       done
);

  logic [8:0]         progMem [progDepth];
  cpuPkg::fetchStateE state;

  always_ff @(posedge clk) begin
    if (progWe && (int'(progAddr) < progDepth)) progMem[progAddr] <= progData;
  end

  assign instr  = progMem[pc];
  assign active = (state == cpuPkg::running);
  assign done   = (state == cpuPkg::halted);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= cpuPkg::idle;
      pc    <= 8'd0;
    end else begin
      case (state)
        cpuPkg::running: begin
          if (ctrl.halt) state <= cpuPkg::halted;   // pc holds on halt
          else if (ctrl.branchTaken) pc <= cpuPkg::jumpTable[instr[3:0]];
          else pc <= pc + 8'd1;
        end
        default: begin   // idle or halted
          if (start) begin
            state <= cpuPkg::running;
            pc    <= 8'd0;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/controlDecoder.sv ====
// combinational instruction decoder, resolves branches and picks the write-back source
`default_nettype none

module controlDecoder (
  input  logic [8:0] instr,
  input  logic       active,
  input  logic [7:0] datA,
  input  logic [7:0] datB,
  input  logic [7:0] aluResult,
  input  logic [7:0] memOut,
  ctrlIf.decoder     ctrl,
  output logic [7:0] writeData,
  output logic [7:0] memIn
);

  cpuPkg::opcodeE opcode;
  logic [1:0]     funct;
  logic           wbMove;      // write back register operand A
  logic           tableAddr;   // lb/sb use the address table
  logic           storeFromA;
  logic           isBranch;
  logic           cond;

  assign opcode = cpuPkg::opcodeE'(instr[8:6]);
  assign funct  = instr[5:4];

  always_comb begin
    // defaults that each opcode overrides below
    ctrl.aluOp    = cpuPkg::opPassA;
    ctrl.aluSrc   = 1'b0;
    ctrl.regA     = 4'd0;
    ctrl.regB     = 4'd1;
    ctrl.wrAddr   = instr[3:0];
    ctrl.regWrite = 1'b1;
    ctrl.memWrite = 1'b0;
    ctrl.memToReg = 1'b0;
    ctrl.immed    = instr[5:1];
    ctrl.halt     = 1'b0;
    wbMove        = 1'b0;
    tableAddr     = 1'b0;
    storeFromA    = 1'b0;
    isBranch      = 1'b0;
    case (opcode)
      cpuPkg::rType0: begin
        case (funct)
          2'b00: ctrl.aluOp = cpuPkg::opAdd;
          2'b01: ctrl.aluOp = cpuPkg::opSub;
          2'b10: ctrl.memToReg = 1'b1;   // load via r0
          2'b11: begin                   // store via r0
            ctrl.regB     = instr[3:0];
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b1;
          end
        endcase
      end
      cpuPkg::loadByte: begin
        tableAddr     = 1'b1;
        ctrl.wrAddr   = {3'b000, instr[0]};
        ctrl.memToReg = 1'b1;
      end
      cpuPkg::storeByte: begin
        tableAddr     = 1'b1;
        storeFromA    = 1'b1;
        ctrl.regA     = {3'b000, instr[0]};
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b1;
      end
      cpuPkg::addImm: begin
        ctrl.wrAddr = 4'd1;
        ctrl.aluSrc = 1'b1;
        ctrl.aluOp  = cpuPkg::opAdd;
      end
      cpuPkg::branch: begin
        isBranch      = 1'b1;
        ctrl.regWrite = 1'b0;
      end
      cpuPkg::move: begin
        wbMove = 1'b1;
        if (instr[5]) begin
          ctrl.regA   = {3'b000, instr[0]};
          ctrl.wrAddr = instr[4:1];
        end else begin
          ctrl.regA   = instr[3:0];
          ctrl.wrAddr = {3'b000, instr[4]};
        end
      end
      cpuPkg::shiftType: begin
        case (funct)
          2'b00: ctrl.aluOp = cpuPkg::opLsl;
          2'b01: ctrl.aluOp = cpuPkg::opAsr;
          2'b10: ctrl.aluOp = cpuPkg::opLsr;
          2'b11: ctrl.aluOp = cpuPkg::opNot;
        endcase
      end
      cpuPkg::logicType: begin
        case (funct)
          2'b00: ctrl.aluOp = cpuPkg::opAnd;
          2'b01: ctrl.aluOp = cpuPkg::opOr;
          2'b10: ctrl.aluOp = cpuPkg::opMul;
          2'b11: begin                   // halt
            ctrl.regWrite = 1'b0;
            ctrl.halt     = 1'b1;
          end
        endcase
      end
      default: ;
    endcase
    if (!active) begin   // no side effects outside running
      ctrl.regWrite = 1'b0;
      ctrl.memWrite = 1'b0;
      ctrl.halt     = 1'b0;
    end
  end

  // data address, store data and branch condition
  always_comb begin
    ctrl.memAddr = tableAddr ? cpuPkg::addrTable[instr[5:1]] : datA;
    memIn        = storeFromA ? datA : datB;
    case (funct)
      2'b00:   cond = (datA == datB);
      2'b01:   cond = (datA != datB);
      2'b10:   cond = (datA < datB);
      default: cond = (datA <= datB);
    endcase
    ctrl.branchTaken = active & isBranch & cond;
  end

  assign writeData = ctrl.memToReg ? memOut : (wbMove ? datA : aluResult);

endmodule

`default_nettype wire

// ==== logic/dataMem.sv ====
// 256-byte data memory, cleared on reset, asynchronous read and synchronous write
`default_nettype none

module dataMem (
  input  logic       clk,
  input  logic       arstN,
  ctrlIf.mem         ctrl,
  input  logic [7:0] memIn,
  output logic [7:0] memOut
);

  logic [7:0] mem [256];

  assign memOut = mem[ctrl.memAddr];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] <= 8'd0;
      end
    end else if (ctrl.memWrite) begin
      mem[ctrl.memAddr] <= memIn;
    end
  end

endmodule

`default_nettype wire

// ==== logic/regFile.sv ====
// sixteen 8-bit registers, two asynchronous read ports and one write port
`default_nettype none

module regFile (
  input  logic       clk,
  input  logic       arstN,
  ctrlIf.rf          ctrl,
  input  logic [7:0] writeData,
  output logic [7:0] datA,
  output logic [7:0] datB
);

  logic [7:0] regs [16];

  assign datA = regs[ctrl.regA];
  assign datB = regs[ctrl.regB];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 8'd0;   // architectural state starts at zero
      end
    end else if (ctrl.regWrite) begin
      regs[ctrl.wrAddr] <= writeData;
    end
  end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
// 8-bit arithmetic, shift and logic unit selected by the decoded ALU operation
`default_nettype none

module alu (
  ctrlIf.ex          ctrl,
  input  logic [7:0] datA,
  input  logic [7:0] datB,
  output logic [7:0] aluResult
);

  logic [7:0] opB;
  logic [2:0] shamt;

  assign opB   = ctrl.aluSrc ? {3'b000, ctrl.immed} : datB;   // addi zero-extends
  assign shamt = opB[2:0];

  always_comb begin
    case (ctrl.aluOp)
      cpuPkg::opAdd:   aluResult = datA + opB;
      cpuPkg::opSub:   aluResult = datA - opB;
      cpuPkg::opLsl:   aluResult = datA << shamt;
      cpuPkg::opAsr:   aluResult = 8'($signed(datA) >>> shamt);
      cpuPkg::opLsr:   aluResult = datA >> shamt;
      cpuPkg::opNot:   aluResult = ~datA;
      cpuPkg::opAnd:   aluResult = datA & opB;
      cpuPkg::opOr:    aluResult = datA | opB;
      cpuPkg::opMul:   aluResult = datA * opB;   // low byte only
      default:         aluResult = datA;         // pass A
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/ctrlIf.sv ====
// decoded control bundle, driven by the decoder and read by fetch, register file, ALU and memory
`default_nettype none

interface ctrlIf;
  cpuPkg::aluOpE aluOp;
  logic          aluSrc;      // selects the immediate operand
  logic [3:0]    regA;
  logic [3:0]    regB;
  logic [3:0]    wrAddr;
  logic          regWrite;
  logic          memWrite;
  logic          memToReg;    // write back from data memory
  logic [4:0]    immed;
  logic [7:0]    memAddr;
  logic          branchTaken;
  logic          halt;

  modport decoder (output aluOp, aluSrc, regA, regB, wrAddr, regWrite, memWrite,
                   memToReg, immed, memAddr, branchTaken, halt);
  modport rf (input regA, regB, wrAddr, regWrite);
  modport ex (input aluOp, aluSrc, immed);
  modport mem (input memAddr, memWrite);
  modport fetch (input branchTaken, halt);
endinterface

`default_nettype wire

// ==== logic/cpuPkg.sv ====
// shared opcode, ALU and fetch-state types plus the lb/sb address and branch target tables
`default_nettype none

package cpuPkg;

  typedef enum logic [2:0] {
    rType0    = 3'b000,
    loadByte  = 3'b001,
    storeByte = 3'b010,
    addImm    = 3'b011,
    branch    = 3'b100,
    move      = 3'b101,
    shiftType = 3'b110,
    logicType = 3'b111
  } opcodeE;

  typedef enum logic [3:0] {
    opAdd, opSub, opLsl, opAsr, opLsr, opNot, opAnd, opOr, opMul, opPassA
  } aluOpE;

  typedef enum logic [1:0] {
    idle, running, halted
  } fetchStateE;

  // data address for each 5-bit lb/sb immediate
  localparam logic [7:0] addrTable [32] = '{
    8'h00, 8'h01, 8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07,
    8'h10, 8'h11, 8'h20, 8'h21, 8'h30, 8'h31, 8'h40, 8'h41,
    8'h50, 8'h60, 8'h70, 8'h80, 8'h90, 8'hA0, 8'hB0, 8'hC0,
    8'hD0, 8'hE0, 8'hF0, 8'hF8, 8'hFC, 8'hFD, 8'hFE, 8'hFF
  };

  // branch targets, indexed by instr[3:0]
  localparam logic [7:0] jumpTable [16] = '{
    8'h00, 8'h08, 8'h10, 8'h18, 8'h20, 8'h28, 8'h30, 8'h38,
    8'h40, 8'h48, 8'h50, 8'h58, 8'h60, 8'h68, 8'h70, 8'h78
  };

endpackage

`default_nettype wire
